// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing -Wall
TOP       = tb_eth_mac_rx
FILELIST  = files.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// File: files.f
verilog/eth_rx_pkg.sv
verilog/xgmii_rx_align.sv
verilog/eth_rx_crc.sv
verilog/eth_rx_fsm.sv
verilog/eth_rx_stats.sv
verilog/eth_mac_rx.sv
tb/tb_eth_mac_rx.sv

// File: tb/tb_eth_mac_rx.sv
/* testbench for eth_mac_rx, frames come from a table and carry a reference CRC-32
   payloads are at least 8 bytes, a cut frame starts in lane 0 and is followed
   at once by a lane-0 frame, all other frames are separated by idle words */
module tb_eth_mac_rx;
    import eth_rx_pkg::*;

    typedef struct packed {
        int len;
        int lane4;
        int bad_fcs;
        int err_pos;
        int cut_words;
    } frame_row_t;

    // err_pos counts from the first payload byte, -1 for none
    // lengths 60 to 67 put the terminate in lanes 0 to 7
    localparam int NUM_ROWS = 23;
    localparam frame_row_t ROWS [NUM_ROWS] = '{
        '{60, 0, 0, -1, 0}, '{61, 0, 0, -1, 0}, '{62, 0, 0, -1, 0}, '{63, 0, 0, -1, 0},
        '{64, 0, 0, -1, 0}, '{65, 0, 0, -1, 0}, '{66, 0, 0, -1, 0}, '{67, 0, 0, -1, 0},
        '{60, 1, 0, -1, 0}, '{61, 1, 0, -1, 0}, '{62, 1, 0, -1, 0}, '{63, 1, 0, -1, 0},
        '{64, 1, 0, -1, 0}, '{65, 1, 0, -1, 0}, '{66, 1, 0, -1, 0}, '{67, 1, 0, -1, 0},
        // bad FCS, errors in the payload and one just after the terminate
        '{62, 0, 1, -1, 0}, '{66, 1, 1, -1, 0}, '{60, 0, 0, 30, 0}, '{48, 0, 0, 3, 0},
        '{62, 0, 0, 67, 0},
        // cut by a new start after 3 words, then a clean frame
        '{64, 0, 0, -1, 3}, '{40, 0, 0, -1, 0}
    };

    logic                  clk;
    logic                  rst;
    xgmii_word_t           xgmii_rx;
    axis_beat_t            rx_axis;
    rx_status_t            rx_status;
    logic [STAT_WIDTH-1:0] frame_count;
    logic [STAT_WIDTH-1:0] bad_frame_count;
    logic [STAT_WIDTH-1:0] bad_fcs_count;

    integer      seed;
    xgmii_word_t words [$];
    logic [7:0]  exp_bytes [$];
    int          exp_len [$];
    logic        exp_bad [$];
    logic        exp_fcs [$];
    logic [7:0]  got [$];
    int          total_bad;
    int          total_fcs;
    int          cycle_count;
    int          cycle_limit;

    eth_mac_rx DUT (
        .clk             (clk),
        .rst             (rst),
        .xgmii_rx        (xgmii_rx),
        .rx_axis         (rx_axis),
        .rx_status       (rx_status),
        .frame_count     (frame_count),
        .bad_frame_count (bad_frame_count),
        .bad_fcs_count   (bad_fcs_count)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // reflected CRC-32, register value before the final inversion
    function automatic logic [31:0] ref_crc32(input logic [7:0] bytes [$]);
        logic [31:0] crc;
        crc = CRC_INIT;
        foreach (bytes[i]) begin
            crc = crc ^ {24'd0, bytes[i]};
            for (int k = 0; k < 8; k++) begin
                crc = crc[0] ? ((crc >> 1) ^ CRC_POLY) : (crc >> 1);
            end
        end
        return crc;
    endfunction

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAIL at time %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("Test failures found");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic build_stimulus();
        logic [7:0]  body [$];
        logic [8:0]  stream [$];
        logic [31:0] fcs;
        xgmii_word_t w;
        int          base;
        int          keep;
        logic        fcs_err;
        logic        bad;
        repeat (16) stream.push_back({1'b1, XGMII_IDLE});
        for (int r = 0; r < NUM_ROWS; r++) begin
            body.delete();
            repeat (4 * ROWS[r].lane4) stream.push_back({1'b1, XGMII_IDLE});
            // start, six preamble bytes and SFD
            stream.push_back({1'b1, XGMII_START});
            repeat (6) stream.push_back(9'h055);
            stream.push_back(9'h0d5);
            base = stream.size();
            repeat (ROWS[r].len) body.push_back(8'($random(seed)));
            fcs = ~ref_crc32(body) ^ ((ROWS[r].bad_fcs != 0) ? 32'h0000_00ff : 32'h0);
            for (int i = 0; i < 32; i += 8) begin
                body.push_back(fcs[i +: 8]);
            end
            foreach (body[i]) begin
                if (ROWS[r].cut_words == 0 || i < 8 * ROWS[r].cut_words) begin
                    stream.push_back({1'b0, body[i]});
                end
            end
            if (ROWS[r].cut_words == 0) begin
                stream.push_back({1'b1, XGMII_TERM});
                repeat (16) stream.push_back({1'b1, XGMII_IDLE});
                while (stream.size() % 8 != 0) begin
                    stream.push_back({1'b1, XGMII_IDLE});
                end
            end
            if (ROWS[r].err_pos >= 0) begin
                stream[base + ROWS[r].err_pos] = {1'b1, XGMII_ERROR};
            end
            // a cut or an error drops the words from the bad one on
            keep = ROWS[r].len;
            if (ROWS[r].cut_words != 0) begin
                keep = 8 * ROWS[r].cut_words;
            end else if (ROWS[r].err_pos >= 0 && ROWS[r].err_pos < ROWS[r].len) begin
                keep = 8 * (ROWS[r].err_pos / 8);
            end
            fcs_err = (ROWS[r].bad_fcs != 0) && (keep == ROWS[r].len);
            bad = fcs_err || (keep != ROWS[r].len);
            for (int i = 0; i < keep; i++) begin
                exp_bytes.push_back(body[i]);
            end
            // error in the first word leaves a single zero byte
            if (keep == 0) begin
                exp_bytes.push_back(8'h00);
            end
            exp_len.push_back((keep == 0) ? 1 : keep);
            exp_bad.push_back(bad);
            exp_fcs.push_back(fcs_err);
            total_bad += int'(bad);
            total_fcs += int'(fcs_err);
        end
        while (stream.size() != 0) begin
            for (int i = 0; i < 8; i++) begin
                {w.ctrl[i], w.data[i*8 +: 8]} = stream.pop_front();
            end
            words.push_back(w);
        end
        cycle_limit = words.size() + 20 * NUM_ROWS;
    endtask

    task automatic close_frame();
        int len;
        if (exp_len.size() == 0) begin
            $display("Test failures found");
            $fatal(1, "a frame came out while no frame was expected");
        end else begin
            len = exp_len.pop_front();
            check_equal(got.size(), len, "frame length");
            foreach (got[i]) begin
                check_equal(got[i], exp_bytes.pop_front(), "payload byte");
            end
            check_equal(rx_axis.tuser, exp_bad[0], "tuser on the last beat");
            check_equal(rx_status.bad_frame, exp_bad.pop_front(), "bad_frame pulse");
            check_equal(rx_status.bad_fcs, exp_fcs.pop_front(), "bad_fcs pulse");
            got.delete();
        end
    endtask

    // collect bytes by tkeep, outputs are sampled away from the rising edge
    always @(negedge clk) begin
        if (!rst && rx_axis.tvalid) begin
            for (int i = 0; i < 8; i++) begin
                if (rx_axis.tkeep[i]) begin
                    got.push_back(rx_axis.tdata[i*8 +: 8]);
                end
            end
            if (rx_axis.tlast) begin
                close_frame();
            end else begin
                check_equal(rx_axis.tkeep, 8'hff, "tkeep of an inner beat");
                check_equal(rx_axis.tuser, 1'b0, "tuser on an inner beat");
            end
        end
        if (!rst && !(rx_axis.tvalid && rx_axis.tlast)) begin
            check_equal(rx_status, 2'b00, "status pulse away from a last beat");
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Test failures found");
            $fatal(1, "timeout, frames still missing after %0d cycles", cycle_limit);
        end
    end

    initial begin
        seed = 32'hb62febae;
        rst = 1'b1;
        xgmii_rx = XGMII_IDLE_WORD;
        build_stimulus();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        // quiet outputs before the first frame
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_equal(rx_axis.tvalid, 1'b0, "tvalid after reset");
        check_equal(rx_status, 2'b00, "status after reset");
        check_equal(frame_count, 0, "frame count after reset");
        check_equal(bad_frame_count, 0, "bad frame count after reset");
        check_equal(bad_fcs_count, 0, "bad FCS count after reset");
        foreach (words[k]) begin
            @(posedge clk);
            #1;
            xgmii_rx = words[k];
        end
        @(posedge clk);
        #1;
        xgmii_rx = XGMII_IDLE_WORD;
        while (exp_len.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(negedge clk);
        check_equal(frame_count, NUM_ROWS, "frame count");
        check_equal(bad_frame_count, total_bad, "bad frame count");
        check_equal(bad_fcs_count, total_fcs, "bad FCS count");
        check_equal(got.size(), 0, "bytes left after the last frame");
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: verilog/eth_mac_rx.sv
/* 10G Ethernet receive path, XGMII in, stream beats out without back-pressure
   data latency is 3 cycles, counters follow the tlast beat by one cycle */
module eth_mac_rx (
    input  logic                              clk,
    input  logic                              rst,
    input  eth_rx_pkg::xgmii_word_t           xgmii_rx,
    output eth_rx_pkg::axis_beat_t            rx_axis,
    output eth_rx_pkg::rx_status_t            rx_status,
    output logic [eth_rx_pkg::STAT_WIDTH-1:0] frame_count,
    output logic [eth_rx_pkg::STAT_WIDTH-1:0] bad_frame_count,
    output logic [eth_rx_pkg::STAT_WIDTH-1:0] bad_fcs_count
);
    import eth_rx_pkg::*;

    xgmii_word_t word_d0;
    xgmii_word_t word_d1;
    crc_lanes_t  crc_now;
    crc_lanes_t  crc_saved;
    logic        crc_reset;
    logic        crc_update;

    xgmii_rx_align u_align (
        .clk      (clk),
        .rst      (rst),
        .xgmii_rx (xgmii_rx),
        .word_d0  (word_d0),
        .word_d1  (word_d1)
    );

    // CRC runs one word ahead of the output word
    eth_rx_crc u_crc (
        .clk        (clk),
        .rst        (rst),
        .data       (word_d0.data),
        .crc_reset  (crc_reset),
        .crc_update (crc_update),
        .crc_now    (crc_now),
        .crc_saved  (crc_saved)
    );

    eth_rx_fsm u_fsm (
        .clk        (clk),
        .rst        (rst),
        .word_d0    (word_d0),
        .word_d1    (word_d1),
        .crc_now    (crc_now),
        .crc_saved  (crc_saved),
        .crc_reset  (crc_reset),
        .crc_update (crc_update),
        .rx_axis    (rx_axis),
        .rx_status  (rx_status)
    );

    eth_rx_stats u_stats (
        .clk             (clk),
        .rst             (rst),
        .rx_axis         (rx_axis),
        .rx_status       (rx_status),
        .frame_count     (frame_count),
        .bad_frame_count (bad_frame_count),
        .bad_fcs_count   (bad_fcs_count)
    );

endmodule

// File: verilog/eth_rx_crc.sv
/* byte-parallel CRC-32 over one 64-bit word, lane 0 first
   crc_now is combinational from the register, crc_saved is the crc_now of the
   last updated word; reset strobe wins over update */
module eth_rx_crc (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [63:0]            data,
    input  logic                   crc_reset,
    input  logic                   crc_update,
    output eth_rx_pkg::crc_lanes_t crc_now,
    output eth_rx_pkg::crc_lanes_t crc_saved
);
    import eth_rx_pkg::*;

    logic [31:0] crc_state;

    // one byte through the reflected LFSR, LSB first
    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            c = (c >> 1) ^ (CRC_POLY & {32{c[0] ^ b[i]}});
        end
        return c;
    endfunction

    // running partials over 1 to 8 leading bytes
    always_comb begin
        logic [31:0] c;
        c = crc_state;
        for (int n = 0; n < 8; n++) begin
            c = crc_byte(c, data[n*8 +: 8]);
            crc_now[n] = c;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            crc_state <= CRC_INIT;
        end else if (crc_reset) begin
            crc_state <= CRC_INIT;
        end else if (crc_update) begin
            crc_state <= crc_now[7];
        end
    end

    // partials of the previous word, for an FCS split over two words
    always_ff @(posedge clk) begin
        if (crc_update && !crc_reset) begin
            crc_saved <= crc_now;
        end
    end

    a_strobe_excl: assert property (@(posedge clk) disable iff (rst)
        !(crc_reset && crc_update));

endmodule

// File: verilog/eth_rx_fsm.sv
/* frame FSM, works on the aligned pipeline, start expected in lane 0 of word_d1
   frames are assumed to be at least 8 payload bytes plus FCS long
   FCS bytes are stripped through tkeep, tdata keeps whatever the lanes held */
module eth_rx_fsm (
    input  logic                    clk,
    input  logic                    rst,
    input  eth_rx_pkg::xgmii_word_t word_d0,
    input  eth_rx_pkg::xgmii_word_t word_d1,
    input  eth_rx_pkg::crc_lanes_t  crc_now,
    input  eth_rx_pkg::crc_lanes_t  crc_saved,
    output logic                    crc_reset,
    output logic                    crc_update,
    output eth_rx_pkg::axis_beat_t  rx_axis,
    output eth_rx_pkg::rx_status_t  rx_status
);
    import eth_rx_pkg::*;

    rx_state_t    state;
    rx_state_t    state_next;

    logic         start_d0;
    logic         start_d1;
    logic [7:0]   det_term;
    logic [7:0]   det_error;
    logic [7:0]   err_masked;
    logic [2:0]   term_lane;

    logic [127:0] pair;
    logic [31:0]  fcs_rx;
    logic [31:0]  fcs_exp;
    logic [7:0]   fcs_keep;
    logic         fcs_bad;

    logic [7:0]   last_keep;
    logic [7:0]   last_keep_next;
    logic         last_bad;
    logic         last_bad_next;

    axis_beat_t   beat_next;
    rx_status_t   status_next;

    assign start_d0 = word_d0.ctrl[0] && (word_d0.data[7:0] == XGMII_START);
    assign start_d1 = word_d1.ctrl[0] && (word_d1.data[7:0] == XGMII_START);

    // per-lane control characters, errors at or after the terminate dropped
    always_comb begin
        logic seen;
        seen = 1'b0;
        term_lane = 3'd0;
        for (int i = 0; i < 8; i++) begin
            det_term[i] = word_d0.ctrl[i] && (word_d0.data[i*8 +: 8] == XGMII_TERM);
            det_error[i] = word_d0.ctrl[i] && (word_d0.data[i*8 +: 8] == XGMII_ERROR);
            if (det_term[i] && !seen) begin
                term_lane = 3'(i);
            end
            seen = seen | det_term[i];
            err_masked[i] = det_error[i] && !seen;
        end
    end

    // FCS sits in the 4 bytes just below the terminate, word_d1 is the low half
    assign pair = {word_d0.data, word_d1.data};

    always_comb begin
        fcs_rx = pair[(int'(term_lane) + 4) * 8 +: 32];
        if (term_lane <= 3'd4) begin
            // FCS starts inside word_d1
            fcs_exp = ~crc_saved[term_lane + 3'd3];
            fcs_keep = 8'hff >> (3'd4 - term_lane);
        end else begin
            // FCS entirely in word_d0, payload spills into an extra beat
            fcs_exp = ~crc_now[term_lane - 3'd5];
            fcs_keep = 8'hff >> (4'd12 - {1'b0, term_lane});
        end
    end

    assign fcs_bad = (fcs_rx != fcs_exp);

    always_comb begin
        state_next = state;
        crc_reset = 1'b0;
        crc_update = 1'b0;
        last_keep_next = last_keep;
        last_bad_next = last_bad;
        beat_next = '0;
        status_next = '0;

        case (state)
            st_idle: begin
                crc_reset = 1'b1;
                if (start_d1) begin
                    if (|err_masked) begin
                        // error in the first word, one bad byte
                        beat_next.tkeep = 8'h01;
                        beat_next.tvalid = 1'b1;
                        beat_next.tlast = 1'b1;
                        beat_next.tuser = 1'b1;
                        status_next.bad_frame = 1'b1;
                    end else begin
                        crc_reset = 1'b0;
                        crc_update = 1'b1;
                        state_next = st_payload;
                    end
                end
            end
            st_payload: begin
                crc_update = 1'b1;
                beat_next.tdata = word_d1.data;
                beat_next.tkeep = ~word_d1.ctrl;
                beat_next.tvalid = 1'b1;
                if (start_d0 || (|err_masked)) begin
                    // cut the frame here, a new start goes through idle
                    crc_reset = 1'b1;
                    crc_update = 1'b0;
                    beat_next.tlast = 1'b1;
                    beat_next.tuser = 1'b1;
                    status_next.bad_frame = 1'b1;
                    state_next = st_idle;
                end else if (|det_term) begin
                    if (term_lane <= 3'd4) begin
                        crc_reset = 1'b1;
                        crc_update = 1'b0;
                        beat_next.tkeep = fcs_keep;
                        beat_next.tlast = 1'b1;
                        beat_next.tuser = fcs_bad;
                        status_next.bad_frame = fcs_bad;
                        status_next.bad_fcs = fcs_bad;
                        state_next = st_idle;
                    end else begin
                        last_keep_next = fcs_keep;
                        last_bad_next = fcs_bad;
                        state_next = st_last;
                    end
                end
            end
            st_last: begin
                // status held back so it lines up with tlast
                crc_reset = 1'b1;
                beat_next.tdata = word_d1.data;
                beat_next.tkeep = last_keep;
                beat_next.tvalid = 1'b1;
                beat_next.tlast = 1'b1;
                beat_next.tuser = last_bad;
                status_next.bad_frame = last_bad;
                status_next.bad_fcs = last_bad;
                state_next = st_idle;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
            rx_axis <= '0;
            rx_status <= '0;
            last_keep <= '0;
            last_bad <= 1'b0;
        end else begin
            state <= state_next;
            rx_axis <= beat_next;
            rx_status <= status_next;
            last_keep <= last_keep_next;
            last_bad <= last_bad_next;
        end
    end

    // a payload word leaving the pipeline holds data in every lane
    a_payload_data: assert property (@(posedge clk) disable iff (rst)
        (state == st_payload) |-> (word_d1.ctrl == 8'h00));

endmodule

// File: verilog/eth_rx_pkg.sv
/* shared definitions for the 10G receive path
   XGMII lanes are little endian, lane 0 in data[7:0] and ctrl[0]
   CRC-32 is the reflected Ethernet polynomial, LSB of each byte first */
package eth_rx_pkg;

    // XGMII control characters
    localparam logic [7:0] XGMII_IDLE  = 8'h07;
    localparam logic [7:0] XGMII_START = 8'hfb;
    localparam logic [7:0] XGMII_TERM  = 8'hfd;
    localparam logic [7:0] XGMII_ERROR = 8'hfe;

    // CRC-32, reflected form of 0x04c11db7
    localparam logic [31:0] CRC_POLY = 32'hedb88320;
    localparam logic [31:0] CRC_INIT = 32'hffffffff;

    // width of the statistics counters
    localparam int STAT_WIDTH = 16;

    typedef struct packed {
        logic [63:0] data;
        logic [7:0]  ctrl;
    } xgmii_word_t;

    // all lanes idle, also the pipeline value out of reset
    localparam xgmii_word_t XGMII_IDLE_WORD = '{data: {8{XGMII_IDLE}}, ctrl: 8'hff};

    typedef struct packed {
        logic [63:0] tdata;
        logic [7:0]  tkeep;
        logic        tvalid;
        logic        tlast;
        logic        tuser;
    } axis_beat_t;

    typedef struct packed {
        logic bad_frame;
        logic bad_fcs;
    } rx_status_t;

    // entry n holds the CRC after n+1 bytes of a word
    typedef logic [7:0][31:0] crc_lanes_t;

    typedef enum logic [1:0] {
        st_idle,
        st_payload,
        st_last
    } rx_state_t;

endpackage

// File: verilog/eth_rx_stats.sv
/* saturating receive counters, each holds at its maximum
   frame_count includes bad frames */
module eth_rx_stats (
    input  logic                                clk,
    input  logic                                rst,
    input  eth_rx_pkg::axis_beat_t              rx_axis,
    input  eth_rx_pkg::rx_status_t              rx_status,
    output logic [eth_rx_pkg::STAT_WIDTH-1:0]   frame_count,
    output logic [eth_rx_pkg::STAT_WIDTH-1:0]   bad_frame_count,
    output logic [eth_rx_pkg::STAT_WIDTH-1:0]   bad_fcs_count
);
    import eth_rx_pkg::*;

    function automatic logic [STAT_WIDTH-1:0] sat_inc(
        input logic [STAT_WIDTH-1:0] value,
        input logic                  en
    );
        return (en && (value != '1)) ? value + 1'b1 : value;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            frame_count <= '0;
            bad_frame_count <= '0;
            bad_fcs_count <= '0;
        end else begin
            frame_count <= sat_inc(frame_count, rx_axis.tvalid && rx_axis.tlast);
            bad_frame_count <= sat_inc(bad_frame_count, rx_status.bad_frame);
            bad_fcs_count <= sat_inc(bad_fcs_count, rx_status.bad_fcs);
        end
    end

    // every FCS error is also counted as a bad frame
    a_fcs_le_bad: assert property (@(posedge clk) disable iff (rst)
        bad_fcs_count <= bad_frame_count);

endmodule

// File: verilog/xgmii_rx_align.sv
/* start accepted in lane 0 or lane 4, lane-4 frames are shifted down by 4 lanes
   a lane-0 start right after a lane-4 frame needs one idle word between them */
module xgmii_rx_align (
    input  logic                    clk,
    input  logic                    rst,
    input  eth_rx_pkg::xgmii_word_t xgmii_rx,
    output eth_rx_pkg::xgmii_word_t word_d0,
    output eth_rx_pkg::xgmii_word_t word_d1
);
    import eth_rx_pkg::*;

    logic        swapped;
    logic [31:0] swap_data;
    logic [3:0]  swap_ctrl;
    logic        start_lane0;
    logic        start_lane4;

    assign start_lane0 = xgmii_rx.ctrl[0] && (xgmii_rx.data[7:0] == XGMII_START);
    assign start_lane4 = xgmii_rx.ctrl[4] && (xgmii_rx.data[39:32] == XGMII_START);

    // upper half of every word, joined with the next lower half when swapped
    always_ff @(posedge clk) begin
        swap_data <= xgmii_rx.data[63:32];
        swap_ctrl <= xgmii_rx.ctrl[7:4];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            swapped <= 1'b0;
            word_d0 <= XGMII_IDLE_WORD;
            word_d1 <= XGMII_IDLE_WORD;
        end else begin
            if (start_lane0) begin
                swapped <= 1'b0;
                word_d0 <= xgmii_rx;
            end else if (start_lane4) begin
                swapped <= 1'b1;
                if (swapped) begin
                    word_d0.data <= {xgmii_rx.data[31:0], swap_data};
                    word_d0.ctrl <= {xgmii_rx.ctrl[3:0], swap_ctrl};
                end else begin
                    // lower half may still carry the end of an aligned frame
                    word_d0.data <= {{4{XGMII_IDLE}}, xgmii_rx.data[31:0]};
                    word_d0.ctrl <= {4'hf, xgmii_rx.ctrl[3:0]};
                end
            end else if (swapped) begin
                word_d0.data <= {xgmii_rx.data[31:0], swap_data};
                word_d0.ctrl <= {xgmii_rx.ctrl[3:0], swap_ctrl};
            end else begin
                word_d0 <= xgmii_rx;
            end
            word_d1 <= word_d0;
        end
    end

    // aligned stream carries at most one start per word
    a_single_start: assert property (@(posedge clk) disable iff (rst)
        !(word_d0.ctrl[0] && (word_d0.data[7:0] == XGMII_START) &&
          word_d0.ctrl[4] && (word_d0.data[39:32] == XGMII_START)));

endmodule
